/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
LINTFLAGS := --lint-only --timing --timescale 1ns/100ps -Wall
TOP       := etx_tb
FILELIST  := etx.f
OBJ_DIR   := obj_dir
SIM_ARGS  := +verilator+error+limit+1000
PASS_MSG  := TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# status comes from the search for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* etx.f */
src/etx_pkg.sv
src/etx_fifo.sv
src/etx_arbiter.sv
src/etx_framer.sv
src/etx_top.sv
testbench/etx_tb_chk.sv
testbench/etx_tb.sv

/* src/etx_arbiter.sv */
module etx_arbiter
  import etx_pkg::*;
(
  input  logic                  tx_lclk_par,
  input  logic                  reset,
  // write channel
  input  logic                  emwr_fifo_access,
  input  logic                  emwr_fifo_write,
  input  logic [DATAMODE_W-1:0] emwr_fifo_datamode,
  input  logic [CTRLMODE_W-1:0] emwr_fifo_ctrlmode,
  input  logic [ADDR_W-1:0]     emwr_fifo_dstaddr,
  input  logic [ADDR_W-1:0]     emwr_fifo_data,
  input  logic [ADDR_W-1:0]     emwr_fifo_srcaddr,
  output logic                  emwr_rd_en,
  // read request channel
  input  logic                  emrq_fifo_access,
  input  logic                  emrq_fifo_write,
  input  logic [DATAMODE_W-1:0] emrq_fifo_datamode,
  input  logic [CTRLMODE_W-1:0] emrq_fifo_ctrlmode,
  input  logic [ADDR_W-1:0]     emrq_fifo_dstaddr,
  input  logic [ADDR_W-1:0]     emrq_fifo_data,
  input  logic [ADDR_W-1:0]     emrq_fifo_srcaddr,
  output logic                  emrq_rd_en,
  // read response channel
  input  logic                  emrr_fifo_access,
  input  logic                  emrr_fifo_write,
  input  logic [DATAMODE_W-1:0] emrr_fifo_datamode,
  input  logic [CTRLMODE_W-1:0] emrr_fifo_ctrlmode,
  input  logic [ADDR_W-1:0]     emrr_fifo_dstaddr,
  input  logic [ADDR_W-1:0]     emrr_fifo_data,
  input  logic [ADDR_W-1:0]     emrr_fifo_srcaddr,
  output logic                  emrr_rd_en,
  // eMesh master port toward the framer
  output logic                  etx_access,
  output logic                  etx_write,
  output logic [DATAMODE_W-1:0] etx_datamode,
  output logic [CTRLMODE_W-1:0] etx_ctrlmode,
  output logic [ADDR_W-1:0]     etx_dstaddr,
  output logic [ADDR_W-1:0]     etx_data,
  output logic [ADDR_W-1:0]     etx_srcaddr,
  // link flow control
  input  logic                  etx_rd_wait,
  input  logic                  etx_wr_wait,
  input  logic                  etx_ack
);

  logic wr_ready;
  logic rq_ready;
  logic rr_ready;
  logic slot_free;

  // ##########################################################################
  // fixed priority, writes > read requests > read responses
  // ##########################################################################

  // wr_wait blocks writes and responses, rd_wait blocks requests
  assign wr_ready = emwr_fifo_access & ~etx_wr_wait;
  assign rq_ready = emrq_fifo_access & ~etx_rd_wait & ~wr_ready;
  assign rr_ready = emrr_fifo_access & ~etx_wr_wait & ~wr_ready & ~rq_ready;

  // output register empty, or its transaction ends this cycle
  assign slot_free = ~etx_access | etx_ack;

  assign emwr_rd_en = wr_ready & slot_free;
  assign emrq_rd_en = rq_ready & slot_free;
  assign emrr_rd_en = rr_ready & slot_free;

  // held flag
  always_ff @(posedge tx_lclk_par)
  begin
    if (reset)
      etx_access <= 1'b0;
    else if (emwr_rd_en | emrq_rd_en | emrr_rd_en)
      etx_access <= 1'b1;
    else if (etx_ack)
      etx_access <= 1'b0;
  end

  // held payload, loaded with the winner on pop
  always_ff @(posedge tx_lclk_par)
  begin
    if (emwr_rd_en)
    begin
      etx_write    <= 1'b1;
      etx_datamode <= emwr_fifo_datamode;
      etx_ctrlmode <= emwr_fifo_ctrlmode;
      etx_dstaddr  <= emwr_fifo_dstaddr;
      etx_data     <= emwr_fifo_data;
      etx_srcaddr  <= emwr_fifo_srcaddr;
    end
    else if (emrq_rd_en)
    begin
      // requests always go out as reads
      etx_write    <= 1'b0;
      etx_datamode <= emrq_fifo_datamode;
      etx_ctrlmode <= emrq_fifo_ctrlmode;
      etx_dstaddr  <= emrq_fifo_dstaddr;
      etx_data     <= emrq_fifo_data;
      etx_srcaddr  <= emrq_fifo_srcaddr;
    end
    else if (emrr_rd_en)
    begin
      // responses travel as writes back to the requester
      etx_write    <= 1'b1;
      etx_datamode <= emrr_fifo_datamode;
      etx_ctrlmode <= emrr_fifo_ctrlmode;
      etx_dstaddr  <= emrr_fifo_dstaddr;
      etx_data     <= emrr_fifo_data;
      etx_srcaddr  <= emrr_fifo_srcaddr;
    end
  end

endmodule

/* src/etx_fifo.sv */
module etx_fifo
  import etx_pkg::*;
#(
  parameter int DEPTH = 8
) (
  input  logic                  tx_lclk_par,
  input  logic                  reset,
  // host push side
  input  logic                  push,
  input  logic                  write,
  input  logic [DATAMODE_W-1:0] datamode,
  input  logic [CTRLMODE_W-1:0] ctrlmode,
  input  logic [ADDR_W-1:0]     dstaddr,
  input  logic [ADDR_W-1:0]     data,
  input  logic [ADDR_W-1:0]     srcaddr,
  output logic                  full,
  // head entry toward the arbiter
  input  logic                  rd_en,
  output logic                  fifo_access,
  output logic                  fifo_write,
  output logic [DATAMODE_W-1:0] fifo_datamode,
  output logic [CTRLMODE_W-1:0] fifo_ctrlmode,
  output logic [ADDR_W-1:0]     fifo_dstaddr,
  output logic [ADDR_W-1:0]     fifo_data,
  output logic [ADDR_W-1:0]     fifo_srcaddr
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [TRANS_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               do_push;
  logic               do_pop;

  // push while full is dropped, pop only with data present
  assign do_push = push & ~full;
  assign do_pop  = rd_en & fifo_access;

  assign full        = (count == CNT_W'(DEPTH));
  assign fifo_access = (count != '0);

  // ##########################################################################
  // pointers and occupancy
  // ##########################################################################

  always_ff @(posedge tx_lclk_par)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
      begin
        // wrap explicitly, depth need not be a power of two
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      if (do_push & ~do_pop)
        count <= count + 1'b1;
      else if (do_pop & ~do_push)
        count <= count - 1'b1;
    end
  end

  // storage, packed in field order
  always_ff @(posedge tx_lclk_par)
  begin
    if (do_push)
      mem[wr_ptr] <= {write, datamode, ctrlmode, dstaddr, data, srcaddr};
  end

  // first word fall through, head shown directly
  assign {fifo_write, fifo_datamode, fifo_ctrlmode,
          fifo_dstaddr, fifo_data, fifo_srcaddr} = mem[rd_ptr];

endmodule

/* src/etx_framer.sv */
module etx_framer
  import etx_pkg::*;
(
  input  logic                  tx_lclk_par,
  input  logic                  reset,
  // held transaction from the arbiter
  input  logic                  etx_access,
  input  logic                  etx_write,
  input  logic [DATAMODE_W-1:0] etx_datamode,
  input  logic [CTRLMODE_W-1:0] etx_ctrlmode,
  input  logic [ADDR_W-1:0]     etx_dstaddr,
  input  logic [ADDR_W-1:0]     etx_data,
  input  logic [ADDR_W-1:0]     etx_srcaddr,
  output logic                  etx_ack,
  // link side
  input  logic                  tx_wait,
  output logic                  tx_frame,
  output logic [ADDR_W-1:0]     tx_data
);

  framer_state_t     state;
  framer_state_t     state_next;
  logic              word_xfer;
  logic              word_load;
  logic [ADDR_W-1:0] word_next;
  logic [ADDR_W-1:0] header_word;

  // ##########################################################################
  // header word
  // ##########################################################################

  always_comb
  begin
    header_word      = '0;
    header_word[8]   = etx_write;
    header_word[5:4] = etx_datamode;
    header_word[3:0] = etx_ctrlmode;
  end

  // frame active in every state but idle
  assign tx_frame = (state != IDLE);

  // word leaves on an unstalled edge
  assign word_xfer = tx_frame & ~tx_wait;

  // ack with the srcaddr transfer, ends the held transaction
  assign etx_ack = (state == SRCADDR) & ~tx_wait;

  // ##########################################################################
  // sequence
  // ##########################################################################

  always_comb
  begin
    state_next = state;
    word_load  = 1'b0;
    word_next  = etx_dstaddr;
    case (state)
      IDLE:
      begin
        // start a frame, header goes out next cycle
        if (etx_access)
        begin
          state_next = HEADER;
          word_load  = 1'b1;
          word_next  = header_word;
        end
      end
      HEADER:
      begin
        if (word_xfer)
        begin
          state_next = DSTADDR;
          word_load  = 1'b1;
          word_next  = etx_dstaddr;
        end
      end
      DSTADDR:
      begin
        if (word_xfer)
        begin
          state_next = DATA;
          word_load  = 1'b1;
          word_next  = etx_data;
        end
      end
      DATA:
      begin
        if (word_xfer)
        begin
          state_next = SRCADDR;
          word_load  = 1'b1;
          word_next  = etx_srcaddr;
        end
      end
      SRCADDR:
      begin
        // arbiter reloads during this edge
        // next frame starts from idle one cycle later
        if (word_xfer)
          state_next = IDLE;
      end
      default:
      begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge tx_lclk_par)
  begin
    if (reset)
      state <= IDLE;
    else
      state <= state_next;
  end

  // link word register, held while stalled
  always_ff @(posedge tx_lclk_par)
  begin
    if (word_load)
      tx_data <= word_next;
  end

endmodule

/* src/etx_pkg.sv */
package etx_pkg;

  // ##########################################################################
  // eMesh transaction fields
  // ##########################################################################

  // data-mode field, transfer size code
  localparam int DATAMODE_W = 2;

  // control-mode field
  localparam int CTRLMODE_W = 4;

  // dstaddr, srcaddr and data all share this width
  localparam int ADDR_W = 32;

  // packed transaction as stored in the channel FIFOs
  // write + datamode + ctrlmode + dstaddr + data + srcaddr
  localparam int TRANS_W = 1 + DATAMODE_W + CTRLMODE_W + 3 * ADDR_W;

  // ##########################################################################
  // buffering and link framing
  // ##########################################################################

  // entries per channel FIFO
  localparam int FIFO_DEPTH = 8;

  // link words per transaction frame
  // header, dstaddr, data, srcaddr
  localparam int FRAME_WORDS = 4;

  // header word layout
  //   bit 8     write
  //   bits 5:4  datamode
  //   bits 3:0  ctrlmode
  //   all other bits zero

  // framer sequence, one state per link word plus idle
  typedef enum logic [2:0] {
    IDLE,
    HEADER,
    DSTADDR,
    DATA,
    SRCADDR
  } framer_state_t;

endpackage

/* src/etx_top.sv */
module etx_top
  import etx_pkg::*;
(
  input  logic                  tx_lclk_par,
  input  logic                  reset,
  // host write channel
  input  logic                  wr_push,
  input  logic                  wr_write,
  input  logic [DATAMODE_W-1:0] wr_datamode,
  input  logic [CTRLMODE_W-1:0] wr_ctrlmode,
  input  logic [ADDR_W-1:0]     wr_dstaddr,
  input  logic [ADDR_W-1:0]     wr_data,
  input  logic [ADDR_W-1:0]     wr_srcaddr,
  output logic                  wr_full,
  // host read request channel
  input  logic                  rq_push,
  input  logic                  rq_write,
  input  logic [DATAMODE_W-1:0] rq_datamode,
  input  logic [CTRLMODE_W-1:0] rq_ctrlmode,
  input  logic [ADDR_W-1:0]     rq_dstaddr,
  input  logic [ADDR_W-1:0]     rq_data,
  input  logic [ADDR_W-1:0]     rq_srcaddr,
  output logic                  rq_full,
  // host read response channel
  input  logic                  rr_push,
  input  logic                  rr_write,
  input  logic [DATAMODE_W-1:0] rr_datamode,
  input  logic [CTRLMODE_W-1:0] rr_ctrlmode,
  input  logic [ADDR_W-1:0]     rr_dstaddr,
  input  logic [ADDR_W-1:0]     rr_data,
  input  logic [ADDR_W-1:0]     rr_srcaddr,
  output logic                  rr_full,
  // link
  input  logic                  tx_wr_wait,
  input  logic                  tx_rd_wait,
  input  logic                  tx_wait,
  output logic                  tx_frame,
  output logic [ADDR_W-1:0]     tx_data
);

  // ##########################################################################
  // fifo to arbiter
  // ##########################################################################

  logic                  emwr_access, emrq_access, emrr_access;
  logic                  emwr_write, emrq_write, emrr_write;
  logic [DATAMODE_W-1:0] emwr_datamode, emrq_datamode, emrr_datamode;
  logic [CTRLMODE_W-1:0] emwr_ctrlmode, emrq_ctrlmode, emrr_ctrlmode;
  logic [ADDR_W-1:0]     emwr_dstaddr, emrq_dstaddr, emrr_dstaddr;
  logic [ADDR_W-1:0]     emwr_data, emrq_data, emrr_data;
  logic [ADDR_W-1:0]     emwr_srcaddr, emrq_srcaddr, emrr_srcaddr;
  logic                  emwr_rd_en, emrq_rd_en, emrr_rd_en;

  // arbiter to framer
  logic                  etx_access;
  logic                  etx_write;
  logic [DATAMODE_W-1:0] etx_datamode;
  logic [CTRLMODE_W-1:0] etx_ctrlmode;
  logic [ADDR_W-1:0]     etx_dstaddr;
  logic [ADDR_W-1:0]     etx_data;
  logic [ADDR_W-1:0]     etx_srcaddr;
  logic                  etx_ack;

  etx_fifo #(.DEPTH(FIFO_DEPTH)) i_wr_fifo (
    .tx_lclk_par (tx_lclk_par),   .reset         (reset),
    .push        (wr_push),       .write         (wr_write),
    .datamode    (wr_datamode),   .ctrlmode      (wr_ctrlmode),
    .dstaddr     (wr_dstaddr),    .data          (wr_data),
    .srcaddr     (wr_srcaddr),    .full          (wr_full),
    .rd_en       (emwr_rd_en),    .fifo_access   (emwr_access),
    .fifo_write  (emwr_write),    .fifo_datamode (emwr_datamode),
    .fifo_ctrlmode (emwr_ctrlmode), .fifo_dstaddr (emwr_dstaddr),
    .fifo_data   (emwr_data),     .fifo_srcaddr  (emwr_srcaddr)
  );

  etx_fifo #(.DEPTH(FIFO_DEPTH)) i_rq_fifo (
    .tx_lclk_par (tx_lclk_par),   .reset         (reset),
    .push        (rq_push),       .write         (rq_write),
    .datamode    (rq_datamode),   .ctrlmode      (rq_ctrlmode),
    .dstaddr     (rq_dstaddr),    .data          (rq_data),
    .srcaddr     (rq_srcaddr),    .full          (rq_full),
    .rd_en       (emrq_rd_en),    .fifo_access   (emrq_access),
    .fifo_write  (emrq_write),    .fifo_datamode (emrq_datamode),
    .fifo_ctrlmode (emrq_ctrlmode), .fifo_dstaddr (emrq_dstaddr),
    .fifo_data   (emrq_data),     .fifo_srcaddr  (emrq_srcaddr)
  );

  etx_fifo #(.DEPTH(FIFO_DEPTH)) i_rr_fifo (
    .tx_lclk_par (tx_lclk_par),   .reset         (reset),
    .push        (rr_push),       .write         (rr_write),
    .datamode    (rr_datamode),   .ctrlmode      (rr_ctrlmode),
    .dstaddr     (rr_dstaddr),    .data          (rr_data),
    .srcaddr     (rr_srcaddr),    .full          (rr_full),
    .rd_en       (emrr_rd_en),    .fifo_access   (emrr_access),
    .fifo_write  (emrr_write),    .fifo_datamode (emrr_datamode),
    .fifo_ctrlmode (emrr_ctrlmode), .fifo_dstaddr (emrr_dstaddr),
    .fifo_data   (emrr_data),     .fifo_srcaddr  (emrr_srcaddr)
  );

  // link waits map onto the arbiter wait classes
  etx_arbiter i_arbiter (
    .tx_lclk_par        (tx_lclk_par),
    .reset              (reset),
    .emwr_fifo_access   (emwr_access),
    .emwr_fifo_write    (emwr_write),
    .emwr_fifo_datamode (emwr_datamode),
    .emwr_fifo_ctrlmode (emwr_ctrlmode),
    .emwr_fifo_dstaddr  (emwr_dstaddr),
    .emwr_fifo_data     (emwr_data),
    .emwr_fifo_srcaddr  (emwr_srcaddr),
    .emwr_rd_en         (emwr_rd_en),
    .emrq_fifo_access   (emrq_access),
    .emrq_fifo_write    (emrq_write),
    .emrq_fifo_datamode (emrq_datamode),
    .emrq_fifo_ctrlmode (emrq_ctrlmode),
    .emrq_fifo_dstaddr  (emrq_dstaddr),
    .emrq_fifo_data     (emrq_data),
    .emrq_fifo_srcaddr  (emrq_srcaddr),
    .emrq_rd_en         (emrq_rd_en),
    .emrr_fifo_access   (emrr_access),
    .emrr_fifo_write    (emrr_write),
    .emrr_fifo_datamode (emrr_datamode),
    .emrr_fifo_ctrlmode (emrr_ctrlmode),
    .emrr_fifo_dstaddr  (emrr_dstaddr),
    .emrr_fifo_data     (emrr_data),
    .emrr_fifo_srcaddr  (emrr_srcaddr),
    .emrr_rd_en         (emrr_rd_en),
    .etx_access         (etx_access),
    .etx_write          (etx_write),
    .etx_datamode       (etx_datamode),
    .etx_ctrlmode       (etx_ctrlmode),
    .etx_dstaddr        (etx_dstaddr),
    .etx_data           (etx_data),
    .etx_srcaddr        (etx_srcaddr),
    .etx_rd_wait        (tx_rd_wait),
    .etx_wr_wait        (tx_wr_wait),
    .etx_ack            (etx_ack)
  );

  etx_framer i_framer (
    .tx_lclk_par  (tx_lclk_par),
    .reset        (reset),
    .etx_access   (etx_access),
    .etx_write    (etx_write),
    .etx_datamode (etx_datamode),
    .etx_ctrlmode (etx_ctrlmode),
    .etx_dstaddr  (etx_dstaddr),
    .etx_data     (etx_data),
    .etx_srcaddr  (etx_srcaddr),
    .etx_ack      (etx_ack),
    .tx_wait      (tx_wait),
    .tx_frame     (tx_frame),
    .tx_data      (tx_data)
  );

endmodule

/* testbench/etx_tb.sv */
module etx_tb
  import etx_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // ##########################################################################
  // run parameters
  // ##########################################################################

  localparam int          CLK_PERIOD   = 8;
  localparam int          RESET_CYCLES = 8;
  localparam logic [31:0] SEED         = 32'hbdbb_ead6;
  // longest run of tx_wait in the back-pressure test
  localparam int          MAX_STALL    = 3;
  localparam int          RAND_FRAMES  = 36;
  // frames reaching the link over all six tests
  localparam int          TOTAL_FRAMES = 1 + 1 + 9 + RAND_FRAMES + 9 + FIFO_DEPTH;
  localparam int          MARGIN_CYC   = 2000;
  // each word stalled to the limit plus a bubble, margin covers pushes
  localparam int          WATCHDOG_NS  =
    (TOTAL_FRAMES * FRAME_WORDS * (MAX_STALL + 2) + MARGIN_CYC) * CLK_PERIOD;

  // channel index, tag in dstaddr[31:30] is index + 1
  localparam logic [1:0]  CH_WR = 2'd0;
  localparam logic [1:0]  CH_RQ = 2'd1;
  localparam logic [1:0]  CH_RR = 2'd2;

  // word 0 is the header
  typedef logic [FRAME_WORDS-1:0][ADDR_W-1:0] frame_t;

  logic                  tx_lclk_par = 1'b0;
  logic                  reset       = 1'b1;
  // host side, one slot per channel
  logic [2:0]            push_v      = '0;
  logic                  write_v [3] = '{default: 1'b0};
  logic [DATAMODE_W-1:0] dm_v    [3] = '{default: '0};
  logic [CTRLMODE_W-1:0] cm_v    [3] = '{default: '0};
  logic [ADDR_W-1:0]     dst_v   [3] = '{default: '0};
  logic [ADDR_W-1:0]     data_v  [3] = '{default: '0};
  logic [ADDR_W-1:0]     src_v   [3] = '{default: '0};
  wire  [2:0]            full_v;
  // link side
  logic                  tx_wr_wait  = 1'b0;
  logic                  tx_rd_wait  = 1'b0;
  logic                  tx_wait     = 1'b0;
  logic                  tx_frame;
  logic [ADDR_W-1:0]     tx_data;
  logic                  stall_en    = 1'b0;
  int                    stall_run   = 0;

  // scoreboard
  frame_t     exp_q [3][$];
  frame_t     rx_q [$];
  logic [1:0] got_chan [$];
  frame_t     cur_frame;
  int         word_count      = 0;
  int         errors          = 0;
  int         checks          = 0;
  int         tests_run       = 0;
  int         tests_failed    = 0;
  int         errors_at_start = 0;

  always #(CLK_PERIOD / 2) tx_lclk_par = ~tx_lclk_par;

  etx_top i_dut (
    .tx_lclk_par (tx_lclk_par), .reset       (reset),
    .wr_push     (push_v[0]),   .wr_write    (write_v[0]),
    .wr_datamode (dm_v[0]),     .wr_ctrlmode (cm_v[0]),
    .wr_dstaddr  (dst_v[0]),    .wr_data     (data_v[0]),
    .wr_srcaddr  (src_v[0]),    .wr_full     (full_v[0]),
    .rq_push     (push_v[1]),   .rq_write    (write_v[1]),
    .rq_datamode (dm_v[1]),     .rq_ctrlmode (cm_v[1]),
    .rq_dstaddr  (dst_v[1]),    .rq_data     (data_v[1]),
    .rq_srcaddr  (src_v[1]),    .rq_full     (full_v[1]),
    .rr_push     (push_v[2]),   .rr_write    (write_v[2]),
    .rr_datamode (dm_v[2]),     .rr_ctrlmode (cm_v[2]),
    .rr_dstaddr  (dst_v[2]),    .rr_data     (data_v[2]),
    .rr_srcaddr  (src_v[2]),    .rr_full     (full_v[2]),
    .tx_wr_wait  (tx_wr_wait),  .tx_rd_wait  (tx_rd_wait),
    .tx_wait     (tx_wait),     .tx_frame    (tx_frame),
    .tx_data     (tx_data)
  );

  // ##########################################################################
  // reference model
  // ##########################################################################

  // expected link words for one transaction
  function automatic frame_t frame_of(input logic [1:0] chan,
                                      input logic [DATAMODE_W-1:0] datamode,
                                      input logic [CTRLMODE_W-1:0] ctrlmode,
                                      input logic [ADDR_W-1:0] dstaddr,
                                      input logic [ADDR_W-1:0] data,
                                      input logic [ADDR_W-1:0] srcaddr);
    frame_t f;
    logic   wbit;
    // requests are reads, writes and responses are writes
    wbit = (chan != CH_RQ);
    f[0] = {23'b0, wbit, 2'b00, datamode, ctrlmode};
    f[1] = dstaddr;
    f[2] = data;
    f[3] = srcaddr;
    return f;
  endfunction

  // random fields, one push cycle, expected frame queued when kept
  task automatic push_txn(input logic [1:0] chan, input logic write, input bit keep);
    logic [DATAMODE_W-1:0] dm;
    logic [CTRLMODE_W-1:0] cm;
    logic [ADDR_W-1:0]     dst;
    logic [ADDR_W-1:0]     data;
    logic [ADDR_W-1:0]     src;
    dm   = DATAMODE_W'($urandom);
    cm   = CTRLMODE_W'($urandom);
    dst  = {2'(chan + 2'd1), 30'($urandom)};
    data = $urandom;
    src  = $urandom;
    @(posedge tx_lclk_par);
    push_v[chan]  <= 1'b1;
    write_v[chan] <= write;
    dm_v[chan]    <= dm;
    cm_v[chan]    <= cm;
    dst_v[chan]   <= dst;
    data_v[chan]  <= data;
    src_v[chan]   <= src;
    if (keep)
      exp_q[chan].push_back(frame_of(chan, dm, cm, dst, data, src));
    @(posedge tx_lclk_par);
    push_v[chan] <= 1'b0;
  endtask

  // until every expected frame arrived, then a quiet window
  task automatic drain();
    while (exp_q[CH_WR].size() + exp_q[CH_RQ].size() + exp_q[CH_RR].size() != 0)
      @(negedge tx_lclk_par);
    repeat (3 * FRAME_WORDS) @(negedge tx_lclk_par);
    checks++;
    assert (rx_q.size() == 0 && word_count == 0)
    else
    begin
      $display("link left a partial frame of %0d words", word_count);
      errors++;
    end
    // all channel FIFOs empty again, no full flag
    checks++;
    assert (full_v === 3'b000)
    else
    begin
      $display("FAIL full_v: got %h expected %h", full_v, 3'b000);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == errors_at_start)
      $display("test %0d %s: passed", tests_run, name);
    else
    begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", tests_run, name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  // ##########################################################################
  // link monitor and scoreboard
  // ##########################################################################

  // shift words in, header lands at index 0 after four transfers
  always @(posedge tx_lclk_par)
  begin
    if (reset)
      word_count = 0;
    else if (tx_frame && !tx_wait)
    begin
      cur_frame  = {tx_data, cur_frame[FRAME_WORDS-1:1]};
      word_count = word_count + 1;
      if (word_count == FRAME_WORDS)
      begin
        rx_q.push_back(cur_frame);
        word_count = 0;
      end
    end
  end

  // per-channel compare, channel found from the dstaddr tag
  always @(negedge tx_lclk_par)
  begin
    frame_t     got;
    frame_t     want;
    logic [1:0] tag;
    logic [1:0] ch;
    while (rx_q.size() != 0)
    begin
      got = rx_q.pop_front();
      tag = got[1][31:30];
      ch  = tag - 2'd1;
      checks++;
      assert (tag != 2'd0 && exp_q[ch].size() != 0)
      else
      begin
        $display("unexpected frame on the link, dstaddr %h", got[1]);
        errors++;
      end
      if (tag != 2'd0 && exp_q[ch].size() != 0)
      begin
        want = exp_q[ch].pop_front();
        got_chan.push_back(ch);
        assert (got === want)
        else
        begin
          $display("FAIL tx_data frame: got %h expected %h", got, want);
          errors++;
        end
      end
    end
  end

  // bounded random back-pressure
  always @(posedge tx_lclk_par)
  begin
    if (stall_en && stall_run < MAX_STALL && $urandom_range(2, 0) == 0)
    begin
      tx_wait   <= 1'b1;
      stall_run <= stall_run + 1;
    end
    else
    begin
      tx_wait   <= 1'b0;
      stall_run <= 0;
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns with frames outstanding", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  // ##########################################################################
  // tests
  // ##########################################################################

  initial
  begin
    logic [1:0] ch;
    void'($urandom(SEED));
    repeat (RESET_CYCLES) @(posedge tx_lclk_par);
    reset <= 1'b0;
    @(posedge tx_lclk_par);

    push_txn(CH_WR, 1'b1, 1'b1);
    drain();
    report_test("single write");

    // pushed write bit must not reach the header
    push_txn(CH_RQ, 1'b1, 1'b1);
    drain();
    report_test("single read request");

    @(posedge tx_lclk_par);
    tx_wr_wait <= 1'b1;
    tx_rd_wait <= 1'b1;
    for (int k = 0; k < 3; k++)
    begin
      push_txn(CH_RR, 1'b0, 1'b1);
      push_txn(CH_RQ, 1'b1, 1'b1);
      push_txn(CH_WR, 1'b0, 1'b1);
    end
    got_chan.delete();
    @(posedge tx_lclk_par);
    tx_wr_wait <= 1'b0;
    tx_rd_wait <= 1'b0;
    drain();
    checks++;
    assert (got_chan.size() == 9)
    else
    begin
      $display("priority test saw %0d frames instead of 9", got_chan.size());
      errors++;
    end
    for (int i = 0; i < got_chan.size(); i++)
    begin
      checks++;
      assert (got_chan[i] == 2'(i / 3))
      else
      begin
        $display("FAIL channel at frame %0d: got %h expected %h", i, got_chan[i], 2'(i / 3));
        errors++;
      end
    end
    report_test("priority");

    @(posedge tx_lclk_par);
    stall_en <= 1'b1;
    repeat (RAND_FRAMES)
    begin
      ch = 2'($urandom_range(2, 0));
      @(negedge tx_lclk_par);
      while (full_v[ch])
        @(negedge tx_lclk_par);
      push_txn(ch, 1'($urandom), 1'b1);
    end
    drain();
    @(posedge tx_lclk_par);
    stall_en <= 1'b0;
    report_test("back-pressure");

    @(posedge tx_lclk_par);
    tx_rd_wait <= 1'b1;
    for (int k = 0; k < 3; k++)
    begin
      push_txn(CH_WR, 1'b1, 1'b1);
      push_txn(CH_RQ, 1'b0, 1'b1);
      push_txn(CH_RR, 1'b1, 1'b1);
    end
    while (exp_q[CH_WR].size() + exp_q[CH_RR].size() != 0)
      @(negedge tx_lclk_par);
    repeat (4 * FRAME_WORDS) @(negedge tx_lclk_par);
    checks++;
    assert (exp_q[CH_RQ].size() == 3)
    else
    begin
      $display("read request sent while tx_rd_wait was high");
      errors++;
    end
    @(posedge tx_lclk_par);
    tx_rd_wait <= 1'b0;
    drain();
    report_test("wait classes");

    @(posedge tx_lclk_par);
    tx_wr_wait <= 1'b1;
    repeat (FIFO_DEPTH) push_txn(CH_WR, 1'b1, 1'b1);
    @(negedge tx_lclk_par);
    checks++;
    assert (full_v[CH_WR] === 1'b1)
    else
    begin
      $display("FAIL wr_full: got %h expected %h", full_v[CH_WR], 1'b1);
      errors++;
    end
    // one push too many, dropped by the FIFO
    push_txn(CH_WR, 1'b1, 1'b0);
    @(posedge tx_lclk_par);
    tx_wr_wait <= 1'b0;
    drain();
    checks++;
    assert (full_v[CH_WR] === 1'b0)
    else
    begin
      $display("FAIL wr_full: got %h expected %h", full_v[CH_WR], 1'b0);
      errors++;
    end
    report_test("full flag");

    // bound checker failures count as well
    errors = errors + i_dut.i_arbiter.i_arb_chk.fail_count
                    + i_dut.i_framer.i_frm_chk.fail_count;
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

/* testbench/etx_tb_chk.sv */
module etx_tb_chk
  import etx_pkg::*;
(
  input logic               tx_lclk_par,
  input logic               reset,
  input logic               etx_access,
  input logic               etx_ack,
  // held transaction, packed
  input logic [TRANS_W-1:0] held,
  input logic [2:0]         rd_en,
  input logic               tx_frame
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // ##########################################################################
  // arbiter to framer handshake
  // ##########################################################################

  // fields frozen until the ack
  held_stable: assert property (@(posedge tx_lclk_par) disable iff (reset)
    etx_access && !etx_ack |=> $stable(held))
  else
  begin
    $error("held transaction changed before etx_ack");
    fail_count++;
  end

  ack_needs_access: assert property (@(posedge tx_lclk_par) disable iff (reset)
    etx_ack |-> etx_access)
  else
  begin
    $error("etx_ack without etx_access");
    fail_count++;
  end

  // one pop per cycle at most
  single_pop: assert property (@(posedge tx_lclk_par) disable iff (reset)
    $onehot0(rd_en))
  else
  begin
    $error("more than one FIFO popped in a cycle");
    fail_count++;
  end

  // quiet link once reset has been seen for a cycle
  quiet_in_reset: assert property (@(posedge tx_lclk_par)
    reset && $past(reset) |-> !tx_frame)
  else
  begin
    $error("tx_frame high during reset");
    fail_count++;
  end

endmodule

bind etx_arbiter etx_tb_chk i_arb_chk (
  .tx_lclk_par (tx_lclk_par),
  .reset       (reset),
  .etx_access  (etx_access),
  .etx_ack     (etx_ack),
  .held        ({etx_write, etx_datamode, etx_ctrlmode, etx_dstaddr, etx_data, etx_srcaddr}),
  .rd_en       ({emwr_rd_en, emrq_rd_en, emrr_rd_en}),
  .tx_frame    (1'b0)
);

bind etx_framer etx_tb_chk i_frm_chk (
  .tx_lclk_par (tx_lclk_par),
  .reset       (reset),
  .etx_access  (etx_access),
  .etx_ack     (etx_ack),
  .held        ({etx_write, etx_datamode, etx_ctrlmode, etx_dstaddr, etx_data, etx_srcaddr}),
  .rd_en       (3'b000),
  .tx_frame    (tx_frame)
);
